//--- flist.f
logic/mul_pkg.sv
logic/mul_req_if.sv
logic/mul_decode.sv
logic/mul_issue.sv
logic/mul_pipe.sv
logic/mul_wb.sv
logic/mul_unit_top.sv
test/mul_checker.sv
test/mul_unit_asserts.sv
test/tb_mul_unit.sv

//--- test/tb_mul_unit.sv
// testbench for the multiply unit, run as top with the checker and the bound assertions
`timescale 1ns/10ps
`default_nettype none

module tb_mul_unit;
    import mul_pkg::*;

    localparam int RESULT_CREDITS = DEF_CREDITS;
    localparam int WAIT_LIMIT     = 100;
    // credit return modes
    localparam int CR_NONE   = 0;
    localparam int CR_ALWAYS = 1;
    localparam int CR_RANDOM = 2;

    logic clk, rst_n, req_i, flush_i, credit_i, stall_o, wb_valid_o, exact_lat;
    logic [2:0]             funct3_i;
    logic [REG_ADDR_W-1:0]  rd_i, wb_rd_o;
    logic [XLEN-1:0]        rs1_data_i, rs2_data_i, alu1_byp_i, alu2_byp_i, wb_data_o;
    byp_src_e               src1_i, src2_i;
    logic [COMMIT_ID_W-1:0] cid_i, wb_cid_o;
    logic [31:0]            lfsr;
    int value_errs, lat_errs, proto_errs, pending, assert_errs, held, credit_mode;
    int tb_errs = 0;

    mul_unit_top #(.RESULT_CREDITS(RESULT_CREDITS)) DUT (.*);

    mul_checker u_checker (.*, .exact_lat_i(exact_lat), .value_errs_o(value_errs),
        .lat_errs_o(lat_errs), .proto_errs_o(proto_errs), .pending_o(pending));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // results taken by the consumer and not yet credited back
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) held <= 0;
        else held <= held + (wb_valid_o ? 1 : 0) - (credit_i ? 1 : 0);
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            v    = {v[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], fb};
        end
        return v;
    endfunction

    // corner values show up often, most negative and -1 included
    function logic [XLEN-1:0] pick_value();
        logic [2:0] k;
        k = 3'(rand_bits(3));
        if (k == 3'd0) return 32'h8000_0000;
        if (k == 3'd1) return 32'hffff_ffff;
        return rand_bits(XLEN);
    endfunction

    function byp_src_e pick_src();
        logic [1:0] s;
        s = 2'(rand_bits(2));
        if (s == 2'b11) s = 2'b00;
        return byp_src_e'(s);
    endfunction

    task automatic drive_credit();
        int outstanding;
        outstanding = held + (wb_valid_o ? 1 : 0);
        if (credit_mode == CR_ALWAYS) credit_i = (outstanding > 0);
        else if (credit_mode == CR_RANDOM) credit_i = (outstanding > 0) && rand_bits(1);
        else credit_i = 1'b0;
    endtask

    task automatic drive_random();
        req_i      = 1'b1;
        flush_i    = (rand_bits(3) == 0);
        funct3_i   = 3'(rand_bits(2));
        rd_i       = REG_ADDR_W'(rand_bits(REG_ADDR_W));
        cid_i      = COMMIT_ID_W'(rand_bits(COMMIT_ID_W));
        rs1_data_i = pick_value();
        rs2_data_i = pick_value();
        alu1_byp_i = pick_value();
        alu2_byp_i = pick_value();
        src1_i     = pick_src();
        src2_i     = pick_src();
    endtask

    // hold the request on the inputs until stall_o is low at an edge
    task automatic wait_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (stall_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            drive_credit();
            @(posedge clk);
            n++;
        end
        if (stall_o) begin
            tb_errs++;
            $display("ERROR at %0t: request still stalled after %0d cycles", $time, n);
        end
        @(negedge clk);
        drive_credit();
    endtask

    task automatic idle_cycle();
        req_i   = 1'b0;
        flush_i = 1'b0;
        @(posedge clk);
        @(negedge clk);
        drive_credit();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        credit_mode = CR_ALWAYS;
        while ((pending != 0 || held != 0) && n < WAIT_LIMIT) begin
            idle_cycle();
            n++;
        end
        if (pending != 0 || held != 0) begin
            tb_errs++;
            $display("ERROR at %0t: %0d results never came back", $time, pending);
        end
    endtask

    initial begin
        int  n;
        logic seen;
        lfsr = 32'd97029;
        {req_i, flush_i, credit_i, funct3_i, rd_i, cid_i} = '0;
        {rs1_data_i, rs2_data_i, alu1_byp_i, alu2_byp_i} = '0;
        src1_i      = SRC_REG;
        src2_i      = SRC_REG;
        credit_mode = CR_ALWAYS;
        exact_lat   = 1'b1;
        rst_n       = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // most negative times -1 on every op, first from registers then via both bypasses
        for (int f = 0; f < 8; f++) begin
            drive_random();
            flush_i    = 1'b0;
            funct3_i   = 3'(f % 4);
            src1_i     = (f < 4) ? SRC_REG : SRC_ALU1;
            src2_i     = (f < 4) ? SRC_REG : SRC_ALU2;
            rs1_data_i = 32'h8000_0000;
            alu1_byp_i = 32'h8000_0000;
            rs2_data_i = 32'hffff_ffff;
            alu2_byp_i = 32'hffff_ffff;
            wait_accept();
        end
        // credits never short, so every result is exactly 2 cycles out
        repeat (150) begin
            drive_random();
            wait_accept();
            if (rand_bits(2) == 0) idle_cycle();
        end
        wait_drain();
        // withhold credits until the buffer fills and stall_o rises
        credit_mode = CR_NONE;
        exact_lat   = 1'b0;
        seen        = 1'b0;
        n           = 0;
        while (!seen && n < 20) begin
            drive_random();
            flush_i = 1'b0;
            @(posedge clk);
            seen = stall_o;
            @(negedge clk);
            drive_credit();
            n++;
        end
        if (!seen) begin
            tb_errs++;
            $display("ERROR at %0t: stall_o never rose while credits were withheld", $time);
        end
        repeat (5) begin
            if (wb_valid_o && held >= RESULT_CREDITS) begin
                tb_errs++;
                $display("ERROR at %0t: writeback while every credit is held", $time);
            end
            @(posedge clk);
            @(negedge clk);
            drive_credit();
        end
        // credits trickle back, stalled request goes first
        credit_mode = CR_RANDOM;
        wait_accept();
        repeat (150) begin
            drive_random();
            wait_accept();
            if (rand_bits(2) == 0) idle_cycle();
        end
        wait_drain();
        assert_errs = DUT.u_wb.u_wb_asserts.fail_cnt + DUT.u_issue.u_issue_asserts.fail_cnt;
        $display("errors: value %0d, latency %0d, protocol %0d, assertion %0d, testbench %0d",
                 value_errs, lat_errs, proto_errs, assert_errs, tb_errs);
        if (value_errs + lat_errs + proto_errs + assert_errs + tb_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // overall run limit
    initial begin
        repeat (20000) @(posedge clk);
        $display("ERROR: simulation did not finish within 20000 cycles");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/mul_unit_asserts.sv
// concurrent checks on credit accounting and the issue stall, bound into writeback and issue
`timescale 1ns/10ps
`default_nettype none

module mul_unit_asserts #(
    parameter int CNT_W       = 2,
    parameter int MAX_CREDITS = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wb_valid,
    input  logic             credit,
    input  logic [CNT_W-1:0] credits,
    input  logic             advance,
    input  logic             stall,
    input  logic             buf_valid
);
    // read by the testbench at the end of the run
    int fail_cnt = 0;

    // results out at the consumer, counted from the port pulses alone
    int held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= 0;
        end else begin
            held <= held + (wb_valid ? 1 : 0) - (credit ? 1 : 0);
        end
    end

    // a writeback needs a free slot on the consumer side
    wb_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (held < MAX_CREDITS))
        else begin
            fail_cnt++;
            $error("writeback issued with no credit left");
        end

    // counter never above its reset value
    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= MAX_CREDITS)
        else begin
            fail_cnt++;
            $error("credit count above the configured maximum");
        end

    // stall only with the slot taken, filled or kept while the pipe was frozen
    stall_needs_full: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> (buf_valid && $past(!advance)))
        else begin
            fail_cnt++;
            $error("stall raised without a request held over a frozen pipe");
        end

endmodule

// writeback side, no buffer here
bind mul_wb mul_unit_asserts #(.CNT_W(CNT_W), .MAX_CREDITS(RESULT_CREDITS)) u_wb_asserts (
    .clk, .rst_n, .wb_valid(wb_valid_o), .credit(credit_i), .credits,
    .advance(advance_o), .stall(1'b0), .buf_valid(1'b0)
);

// issue side, no credits here
bind mul_issue mul_unit_asserts #(.CNT_W(1), .MAX_CREDITS(1)) u_issue_asserts (
    .clk, .rst_n, .wb_valid(1'b0), .credit(1'b0), .credits(1'b0),
    .advance(advance_i), .stall(stall_o), .buf_valid
);

`default_nettype wire

//--- test/mul_checker.sv
// scoreboard for the multiply unit, models each accepted request and checks writebacks in order
`timescale 1ns/10ps
`default_nettype none

module mul_checker (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_i,
    input  logic                            flush_i,
    input  logic [2:0]                      funct3_i,
    input  logic [mul_pkg::REG_ADDR_W-1:0]  rd_i,
    input  logic [mul_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [mul_pkg::XLEN-1:0]        rs2_data_i,
    input  logic [mul_pkg::XLEN-1:0]        alu1_byp_i,
    input  logic [mul_pkg::XLEN-1:0]        alu2_byp_i,
    input  mul_pkg::byp_src_e               src1_i,
    input  mul_pkg::byp_src_e               src2_i,
    input  logic [mul_pkg::COMMIT_ID_W-1:0] cid_i,
    input  logic                            stall_o,
    input  logic                            wb_valid_o,
    input  logic [mul_pkg::XLEN-1:0]        wb_data_o,
    input  logic [mul_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    input  logic [mul_pkg::COMMIT_ID_W-1:0] wb_cid_o,
    input  logic                            exact_lat_i,
    output int                              value_errs_o,
    output int                              lat_errs_o,
    output int                              proto_errs_o,
    output int                              pending_o
);
    import mul_pkg::*;

    // expected writeback plus the cycle it was accepted in
    typedef struct packed {
        logic [XLEN-1:0]        data;
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] cid;
        logic [31:0]            cyc;
    } exp_t;

    exp_t        exp_q[$];
    exp_t        head;
    exp_t        entry;
    logic [31:0] cycle;
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;

    // full 64-bit product, rs1 signed for MULH/MULHSU, rs2 signed only for MULH
    function logic [XLEN-1:0] ref_product(input mul_op_e op, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] wide_a;
        logic [2*XLEN-1:0] wide_b;
        logic [2*XLEN-1:0] p;
        wide_a = (op == MUL_HSS || op == MUL_HSU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        wide_b = (op == MUL_HSS) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        p = wide_a * wide_b;
        return (op == MUL_LO) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            value_errs_o++;
            $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            // retire first, a request accepted now cannot leave on this edge
            if (wb_valid_o) begin
                if (exp_q.size() == 0) begin
                    proto_errs_o++;
                    $display("ERROR at %0t: writeback with no accepted request outstanding",
                             $time);
                end else begin
                    head = exp_q.pop_front();
                    compare("wb_data_o", head.data, wb_data_o);
                    compare("wb_rd_o", 32'(head.rd), 32'(wb_rd_o));
                    compare("wb_cid_o", 32'(head.cid), 32'(wb_cid_o));
                    if (exact_lat_i && (cycle - head.cyc) != 2) begin
                        lat_errs_o++;
                        $display("FAILED at %0t: wb_valid_o latency expected 2, got %0d",
                                 $time, cycle - head.cyc);
                    end
                end
            end
            // acceptance edge, operands as selected right now
            if (req_i && !flush_i && !stall_o) begin
                opa = (src1_i == SRC_ALU1) ? alu1_byp_i :
                      (src1_i == SRC_ALU2) ? alu2_byp_i : rs1_data_i;
                opb = (src2_i == SRC_ALU1) ? alu1_byp_i :
                      (src2_i == SRC_ALU2) ? alu2_byp_i : rs2_data_i;
                entry.data = ref_product(mul_op_e'(funct3_i[1:0]), opa, opb);
                entry.rd   = rd_i;
                entry.cid  = cid_i;
                entry.cyc  = cycle;
                exp_q.push_back(entry);
            end
        end
        pending_o = exp_q.size();
    end

endmodule

`default_nettype wire

//--- logic/mul_unit_top.sv
// multiply unit top level with plain ports, wires decode, issue buffer, pipe and writeback
`timescale 1ns/10ps
`default_nettype none

module mul_unit_top #(
    parameter int RESULT_CREDITS = mul_pkg::DEF_CREDITS
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_i,
    input  logic                            flush_i,
    input  logic [2:0]                      funct3_i,
    input  logic [mul_pkg::REG_ADDR_W-1:0]  rd_i,
    input  logic [mul_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [mul_pkg::XLEN-1:0]        rs2_data_i,
    input  logic [mul_pkg::XLEN-1:0]        alu1_byp_i,
    input  logic [mul_pkg::XLEN-1:0]        alu2_byp_i,
    input  mul_pkg::byp_src_e               src1_i,
    input  mul_pkg::byp_src_e               src2_i,
    input  logic [mul_pkg::COMMIT_ID_W-1:0] cid_i,
    input  logic                            credit_i,
    output logic                            stall_o,
    output logic                            wb_valid_o,
    output logic [mul_pkg::XLEN-1:0]        wb_data_o,
    output logic [mul_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output logic [mul_pkg::COMMIT_ID_W-1:0] wb_cid_o
);
    import mul_pkg::*;

    // decode to issue, issue to pipe
    mul_req_if dec_req ();
    mul_req_if pipe_req ();

    // stage 2 result and the global advance
    logic                   advance;
    logic                   s2_valid;
    logic [XLEN-1:0]        s2_result;
    logic [REG_ADDR_W-1:0]  s2_rd;
    logic [COMMIT_ID_W-1:0] s2_cid;

    mul_decode u_decode (
        .funct3_i, .rd_i, .rs1_data_i, .rs2_data_i, .alu1_byp_i, .alu2_byp_i,
        .src1_i, .src2_i, .cid_i, .req_i, .flush_i, .req(dec_req)
    );

    mul_issue u_issue (
        .clk, .rst_n, .in(dec_req), .out(pipe_req), .advance_i(advance), .stall_o
    );

    mul_pipe u_pipe (
        .clk, .rst_n, .req(pipe_req), .advance_i(advance), .s2_valid_o(s2_valid),
        .result_o(s2_result), .rd_o(s2_rd), .cid_o(s2_cid)
    );

    mul_wb #(.RESULT_CREDITS(RESULT_CREDITS)) u_wb (
        .clk, .rst_n, .s2_valid_i(s2_valid), .result_i(s2_result), .rd_i(s2_rd),
        .cid_i(s2_cid), .credit_i, .advance_o(advance), .wb_valid_o, .wb_data_o,
        .wb_rd_o, .wb_cid_o
    );

endmodule

`default_nettype wire

//--- logic/mul_wb.sv
// credit-gated writeback of stage 2 results, also the advance source for the whole path
`timescale 1ns/10ps
`default_nettype none

module mul_wb #(
    parameter int RESULT_CREDITS = mul_pkg::DEF_CREDITS
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            s2_valid_i,
    input  logic [mul_pkg::XLEN-1:0]        result_i,
    input  logic [mul_pkg::REG_ADDR_W-1:0]  rd_i,
    input  logic [mul_pkg::COMMIT_ID_W-1:0] cid_i,
    input  logic                            credit_i,
    output logic                            advance_o,
    output logic                            wb_valid_o,
    output logic [mul_pkg::XLEN-1:0]        wb_data_o,
    output logic [mul_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output logic [mul_pkg::COMMIT_ID_W-1:0] wb_cid_o
);
    // wide enough to hold RESULT_CREDITS itself
    localparam int CNT_W = $clog2(RESULT_CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic             have_credit;

    assign have_credit = (credits != '0);

    // a result leaves only against a credit
    assign wb_valid_o = s2_valid_i & have_credit;
    assign wb_data_o  = result_i;
    assign wb_rd_o    = rd_i;
    assign wb_cid_o   = cid_i;

    // stage 2 is free or about to drain
    assign advance_o = ~s2_valid_i | have_credit;

    // one credit spent per result, one returned per consumer pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CNT_W'(RESULT_CREDITS);
        end else begin
            case ({credit_i, wb_valid_o})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/mul_pipe.sv
// two-stage 33x33 multiplier for MUL/MULH/MULHSU/MULHU, frozen as a whole by advance
`timescale 1ns/10ps
`default_nettype none

module mul_pipe (
    input  logic                            clk,
    input  logic                            rst_n,
    mul_req_if.dst                          req,
    input  logic                            advance_i,
    output logic                            s2_valid_o,
    output logic [mul_pkg::XLEN-1:0]        result_o,
    output logic [mul_pkg::REG_ADDR_W-1:0]  rd_o,
    output logic [mul_pkg::COMMIT_ID_W-1:0] cid_o
);
    import mul_pkg::*;

    // operands widened by one bit so one signed multiply covers all four ops
    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] prod;
    logic                     a_signed;
    logic                     b_signed;

    // stage 1
    logic                     s1_valid;
    mul_op_e                  s1_op;
    logic [2*XLEN+1:0]        s1_prod;
    logic [REG_ADDR_W-1:0]    s1_rd;
    logic [COMMIT_ID_W-1:0]   s1_cid;

    // rs1 signed for MULH and MULHSU, rs2 only for MULH
    // MUL takes the low word, same for any extension
    assign a_signed = (req.op == MUL_HSS) || (req.op == MUL_HSU);
    assign b_signed = (req.op == MUL_HSS);

    assign a_ext = {a_signed & req.a[XLEN-1], req.a};
    assign b_ext = {b_signed & req.b[XLEN-1], req.b};
    assign prod  = a_ext * b_ext;

    // valids, both stages move together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            s2_valid_o <= 1'b0;
        end else if (advance_i) begin
            s1_valid   <= req.valid;
            s2_valid_o <= s1_valid;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (advance_i && req.valid) begin
            s1_op   <= req.op;
            s1_prod <= prod;
            s1_rd   <= req.rd;
            s1_cid  <= req.cid;
        end
        // stage 2 picks the word to write back
        if (advance_i && s1_valid) begin
            result_o <= (s1_op == MUL_LO) ? s1_prod[XLEN-1:0] : s1_prod[2*XLEN-1:XLEN];
            rd_o     <= s1_rd;
            cid_o    <= s1_cid;
        end
    end

endmodule

`default_nettype wire

//--- logic/mul_issue.sv
// one-entry issue buffer between decode and the multiplier, holds a request over a pipe stall
`timescale 1ns/10ps
`default_nettype none

module mul_issue (
    input  logic    clk,
    input  logic    rst_n,
    mul_req_if.dst  in,
    mul_req_if.src  out,
    input  logic    advance_i,
    output logic    stall_o
);
    import mul_pkg::*;

    // held request, operands already past the bypass mux
    logic                   buf_valid;
    mul_op_e                buf_op;
    logic [XLEN-1:0]        buf_a;
    logic [XLEN-1:0]        buf_b;
    logic [REG_ADDR_W-1:0]  buf_rd;
    logic [COMMIT_ID_W-1:0] buf_cid;

    logic capture;

    // new request while the pipe is frozen and the slot is free
    assign capture = ~buf_valid & in.valid & ~advance_i;

    // slot occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else if (buf_valid) begin
            // drained once the pipe moves
            if (advance_i) begin
                buf_valid <= 1'b0;
            end
        end else if (capture) begin
            buf_valid <= 1'b1;
        end
    end

    // payload, only loaded on capture
    always_ff @(posedge clk) begin
        if (capture) begin
            buf_op  <= in.op;
            buf_a   <= in.a;
            buf_b   <= in.b;
            buf_rd  <= in.rd;
            buf_cid <= in.cid;
        end
    end

    // older buffered request goes first
    assign out.valid = buf_valid | in.valid;
    assign out.op    = buf_valid ? buf_op  : in.op;
    assign out.a     = buf_valid ? buf_a   : in.a;
    assign out.b     = buf_valid ? buf_b   : in.b;
    assign out.rd    = buf_valid ? buf_rd  : in.rd;
    assign out.cid   = buf_valid ? buf_cid : in.cid;

    // slot taken, incoming request has to wait on the inputs
    // it is let in the cycle after the buffer drains
    assign stall_o = buf_valid & in.valid;

endmodule

`default_nettype wire

//--- logic/mul_decode.sv
// combinational decode of a multiply request: funct3 to opcode, operand bypass, flush drop
`timescale 1ns/10ps
`default_nettype none

module mul_decode (
    input  logic [2:0]                      funct3_i,
    input  logic [mul_pkg::REG_ADDR_W-1:0]  rd_i,
    input  logic [mul_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [mul_pkg::XLEN-1:0]        rs2_data_i,
    input  logic [mul_pkg::XLEN-1:0]        alu1_byp_i,
    input  logic [mul_pkg::XLEN-1:0]        alu2_byp_i,
    input  mul_pkg::byp_src_e               src1_i,
    input  mul_pkg::byp_src_e               src2_i,
    input  logic [mul_pkg::COMMIT_ID_W-1:0] cid_i,
    input  logic                            req_i,
    input  logic                            flush_i,
    mul_req_if.src                          req
);
    import mul_pkg::*;

    mul_op_e op;

    // operand select, register file value unless a bypass is named
    function automatic logic [XLEN-1:0] pick_operand(input byp_src_e src,
                                                     input logic [XLEN-1:0] reg_val);
        logic [XLEN-1:0] val;
        case (src)
            SRC_ALU1: val = alu1_byp_i;
            SRC_ALU2: val = alu2_byp_i;
            default:  val = reg_val;
        endcase
        return val;
    endfunction

    // funct3 000..011 are the multiplies
    // division codes are never sent here, fall back to the low product
    always_comb begin
        case (funct3_i)
            3'b001:  op = MUL_HSS;
            3'b010:  op = MUL_HSU;
            3'b011:  op = MUL_HUU;
            default: op = MUL_LO;
        endcase
    end

    // an interrupt flush kills the request in place
    assign req.valid = req_i & ~flush_i;
    assign req.op    = op;
    assign req.a     = pick_operand(src1_i, rs1_data_i);
    assign req.b     = pick_operand(src2_i, rs2_data_i);
    assign req.rd    = rd_i;
    assign req.cid   = cid_i;

endmodule

`default_nettype wire

//--- logic/mul_req_if.sv
// decoded multiply request bundle, used for the decode-to-issue and issue-to-pipe links
`timescale 1ns/10ps
`default_nettype none

interface mul_req_if;
    import mul_pkg::*;

    // request present this cycle
    logic                   valid;
    mul_op_e                op;
    // operands after bypass selection
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    // destination register and commit tag
    logic [REG_ADDR_W-1:0]  rd;
    logic [COMMIT_ID_W-1:0] cid;

    // side that presents the request
    modport src (output valid, op, a, b, rd, cid);

    // side that takes it
    modport dst (input valid, op, a, b, rd, cid);

endinterface

`default_nettype wire

//--- logic/mul_pkg.sv
// shared widths and encodings for the multiply path, imported by every RTL block
`default_nettype none

package mul_pkg;

    // register data width
    localparam int XLEN = 32;
    // destination register index
    localparam int REG_ADDR_W = 5;
    // commit tag carried alongside each result
    localparam int COMMIT_ID_W = 3;

    // results writeback can absorb before a credit comes back
    localparam int DEF_CREDITS = 2;

    // values match funct3[1:0] of the M extension
    typedef enum logic [1:0] {
        MUL_LO  = 2'b00,
        MUL_HSS = 2'b01,
        MUL_HSU = 2'b10,
        MUL_HUU = 2'b11
    } mul_op_e;

    // where an operand comes from
    // code 2'b11 is unused and reads as the register value
    typedef enum logic [1:0] {
        SRC_REG  = 2'b00,
        SRC_ALU1 = 2'b01,
        SRC_ALU2 = 2'b10
    } byp_src_e;

endpackage

`default_nettype wire
